// ==== common/axiMemPkg.sv ====
// shared widths, channel structs and the size helper for the AXI4 memory slave
// only INCR bursts are modelled, so no burst-type field travels with a request
package axiMemPkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  localparam int IdWidth   = 4;
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int StrbWidth = DataWidth / 8;
  localparam int LenWidth  = 8;   // AXI4 burst length, beats minus one
  localparam int SizeWidth = 3;

  localparam int ByteBits = $clog2(StrbWidth);  // byte offset bits within a word

  localparam logic [1:0] RespOkay = 2'b00;

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------

  // one AW or AR request
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
    logic [SizeWidth-1:0] size;
  } burstReq_t;

  // one W beat
  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic                 last;
  } wBeat_t;

  // one R beat
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    logic                 last;
  } rBeat_t;

  // bytes per beat for an AXSIZE value
  function automatic logic [AddrWidth-1:0] sizeBytes(input logic [SizeWidth-1:0] size);
    return AddrWidth'(1) << size;
  endfunction

endpackage

// ==== source/addrFifo.sv ====
// request queue for one address channel, holds up to FifoDepth bursts
// inReady is registered, so it stays low during reset and rises one cycle later
`timescale 1ns/1ns

module addrFifo import axiMemPkg::*; #(
  parameter int FifoDepth = 4
) (
  input  logic      ACLK,
  input  logic      ARESETn,
  input  burstReq_t inReq,
  input  logic      inValid,
  output logic      inReady,
  output burstReq_t outReq,
  output logic      outValid,
  input  logic      outReady
);

  localparam int PtrWidth   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CountWidth = $clog2(FifoDepth + 1);

  burstReq_t slots [FifoDepth];

  logic [PtrWidth-1:0]   wrPtr;
  logic [PtrWidth-1:0]   rdPtr;
  logic [CountWidth-1:0] count;
  logic [CountWidth-1:0] countNext;
  logic                  push;
  logic                  pop;

  assign push     = inValid && inReady;
  assign pop      = outValid && outReady;
  assign outValid = (count != '0);
  assign outReq   = slots[rdPtr];

  always_comb begin
    countNext = count;
    if (push && !pop) countNext = count + 1'b1;
    else if (pop && !push) countNext = count - 1'b1;
  end

  // ----------------------------------------
  // pointers and fill level
  // ----------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      count   <= '0;
      inReady <= 1'b0;
    end else begin
      if (push) wrPtr <= (wrPtr == PtrWidth'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop) rdPtr <= (rdPtr == PtrWidth'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      count   <= countNext;
      inReady <= (countNext != CountWidth'(FifoDepth));  // not full next cycle
    end
  end

  // storage
  always_ff @(posedge ACLK) begin
    if (push) slots[wrPtr] <= inReq;
  end

endmodule

// ==== source/memArray.sv ====
// word memory, byte-lane writes on one port and a registered read on the other
// a read that collides with a write to the same word returns the old word
`timescale 1ns/1ns

module memArray import axiMemPkg::*; #(
  parameter int MemWords = 256
) (
  input  logic                        ACLK,
  input  logic                        wrEn,
  input  logic [$clog2(MemWords)-1:0] wrIndex,
  input  logic [DataWidth-1:0]        wrData,
  input  logic [StrbWidth-1:0]        wrStrb,
  input  logic                        rdEn,
  input  logic [$clog2(MemWords)-1:0] rdIndex,
  output logic [DataWidth-1:0]        rdData
);

  logic [DataWidth-1:0] words [MemWords];

  // ----------------------------------------
  // write port
  // ----------------------------------------
  always_ff @(posedge ACLK) begin
    if (wrEn) begin
      for (int lane = 0; lane < StrbWidth; lane++) begin
        if (wrStrb[lane]) begin
          words[wrIndex][8*lane +: 8] <= wrData[8*lane +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // read port
  // ----------------------------------------
  always_ff @(posedge ACLK) begin
    if (rdEn) rdData <= words[rdIndex];  // data one edge later
  end

endmodule

// ==== writePath/writeEngine.sv ====
// write data phase, one burst at a time, every burst stepped as INCR
// MemWords must be a power of two, addresses wrap inside the memory
`timescale 1ns/1ns

module writeEngine import axiMemPkg::*; #(
  parameter int MemWords = 256
) (
  input  logic                        ACLK,
  input  logic                        ARESETn,
  input  burstReq_t                   req,
  input  logic                        reqValid,
  output logic                        reqReady,
  input  wBeat_t                      wBeat,
  input  logic                        WVALID,
  output logic                        WREADY,
  output logic [IdWidth-1:0]          BID,
  output logic                        BVALID,
  input  logic                        BREADY,
  output logic                        wrEn,
  output logic [$clog2(MemWords)-1:0] wrIndex,
  output logic [DataWidth-1:0]        wrData,
  output logic [StrbWidth-1:0]        wrStrb
);

  localparam int IndexWidth = $clog2(MemWords);

  typedef enum logic [1:0] {
    WrIdle,
    WrData,
    WrResp
  } wrState_t;

  wrState_t             state;
  logic [LenWidth-1:0]  beatsLeft;  // beats after the current one
  logic [IdWidth-1:0]   idQ;
  logic [AddrWidth-1:0] addrQ;
  logic [SizeWidth-1:0] sizeQ;
  logic                 popReq;
  logic                 beatDone;

  assign reqReady = (state == WrIdle);
  assign popReq   = reqValid && reqReady;
  assign WREADY   = (state == WrData);
  assign beatDone = WVALID && WREADY;
  assign BVALID   = (state == WrResp);
  assign BID      = idQ;

  // memory write port, the beat lands at the handshake edge
  // WLAST is not checked, the burst ends on the beat count
  assign wrEn    = beatDone;
  assign wrIndex = addrQ[ByteBits +: IndexWidth];
  assign wrData  = wBeat.data;
  assign wrStrb  = wBeat.strb;

  // ----------------------------------------
  // burst FSM
  // ----------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state     <= WrIdle;
      beatsLeft <= '0;
    end else begin
      case (state)
        WrIdle: begin
          if (popReq) begin
            state     <= WrData;
            beatsLeft <= req.len;
          end
        end
        WrData: begin
          if (beatDone) begin
            if (beatsLeft == '0) state <= WrResp;
            else beatsLeft <= beatsLeft - 1'b1;
          end
        end
        WrResp: begin
          if (BREADY) state <= WrIdle;  // next request may pop now
        end
        default: state <= WrIdle;
      endcase
    end
  end

  // ----------------------------------------
  // burst address and ID
  // ----------------------------------------
  always_ff @(posedge ACLK) begin
    if (popReq) begin
      idQ   <= req.id;
      addrQ <= req.addr;
      sizeQ <= req.size;
    end else if (beatDone) begin
      addrQ <= addrQ + sizeBytes(sizeQ);  // narrow beats step by 1 or 2 bytes
    end
  end

endmodule

// ==== readPath/readEngine.sv ====
// read data phase, one memory read per beat, next fetch only after RREADY
// MemWords must be a power of two, addresses wrap inside the memory
`timescale 1ns/1ns

module readEngine import axiMemPkg::*; #(
  parameter int MemWords = 256
) (
  input  logic                        ACLK,
  input  logic                        ARESETn,
  input  burstReq_t                   req,
  input  logic                        reqValid,
  output logic                        reqReady,
  output rBeat_t                      rBeat,
  output logic                        RVALID,
  input  logic                        RREADY,
  output logic                        rdEn,
  output logic [$clog2(MemWords)-1:0] rdIndex,
  input  logic [DataWidth-1:0]        rdData
);

  localparam int IndexWidth = $clog2(MemWords);

  typedef enum logic [1:0] {
    RdIdle,
    RdFetch,  // memory access
    RdLoad,   // word into the R register
    RdHold    // RVALID up until RREADY
  } rdState_t;

  rdState_t             state;
  logic [LenWidth-1:0]  beatsLeft;
  logic [AddrWidth-1:0] addrQ;
  logic [SizeWidth-1:0] sizeQ;
  rBeat_t               rBeatQ;
  logic                 popReq;

  assign reqReady = (state == RdIdle);
  assign popReq   = reqValid && reqReady;
  assign rdEn     = (state == RdFetch);
  assign rdIndex  = addrQ[ByteBits +: IndexWidth];
  assign RVALID   = (state == RdHold);
  assign rBeat    = rBeatQ;

  // ----------------------------------------
  // burst FSM
  // ----------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state     <= RdIdle;
      beatsLeft <= '0;
    end else begin
      case (state)
        RdIdle: begin
          if (popReq) begin
            state     <= RdFetch;
            beatsLeft <= req.len;
          end
        end
        RdFetch: begin
          state <= RdLoad;
          if (beatsLeft != '0) beatsLeft <= beatsLeft - 1'b1;
        end
        RdLoad: state <= RdHold;
        RdHold: begin
          if (RREADY) state <= rBeatQ.last ? RdIdle : RdFetch;
        end
        default: state <= RdIdle;
      endcase
    end
  end

  // address, ID and the R output register
  always_ff @(posedge ACLK) begin
    if (popReq) begin
      addrQ     <= req.addr;
      sizeQ     <= req.size;
      rBeatQ.id <= req.id;
    end
    if (rdEn) begin
      addrQ       <= addrQ + sizeBytes(sizeQ);
      rBeatQ.last <= (beatsLeft == '0);
    end
    if (state == RdLoad) rBeatQ.data <= rdData;
  end

endmodule

// ==== source/axiMemSlave.sv ====
// AXI4 slave over on-chip memory, INCR bursts only, responses always OKAY
// read and write paths run independently, same-word ordering is not defined
`timescale 1ns/1ns

module axiMemSlave import axiMemPkg::*; #(
  parameter int MemBytes  = 1024,
  parameter int FifoDepth = 4
) (
  input  logic               ACLK,
  input  logic               ARESETn,
  input  burstReq_t          awReq,
  input  logic               AWVALID,
  output logic               AWREADY,
  input  wBeat_t             wBeat,
  input  logic               WVALID,
  output logic               WREADY,
  output logic [IdWidth-1:0] BID,
  output logic               BVALID,
  input  logic               BREADY,
  input  burstReq_t          arReq,
  input  logic               ARVALID,
  output logic               ARREADY,
  output rBeat_t             rBeat,
  output logic [1:0]         RRESP,
  output logic               RVALID,
  input  logic               RREADY
);

  localparam int MemWords   = MemBytes / StrbWidth;
  localparam int IndexWidth = $clog2(MemWords);

  burstReq_t wrReq, rdReq;
  logic wrReqValid, wrReqReady;
  logic rdReqValid, rdReqReady;

  logic                  wrEn, rdEn;
  logic [IndexWidth-1:0] wrIndex, rdIndex;
  logic [DataWidth-1:0]  wrData, rdData;
  logic [StrbWidth-1:0]  wrStrb;

  assign RRESP = RespOkay;

  // ----------------------------------------
  // write path
  // ----------------------------------------
  addrFifo #(.FifoDepth(FifoDepth)) u_awFifo (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .inReq(awReq), .inValid(AWVALID), .inReady(AWREADY),
    .outReq(wrReq), .outValid(wrReqValid), .outReady(wrReqReady)
  );

  writeEngine #(.MemWords(MemWords)) u_writeEngine (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .req(wrReq), .reqValid(wrReqValid), .reqReady(wrReqReady),
    .wBeat(wBeat), .WVALID(WVALID), .WREADY(WREADY),
    .BID(BID), .BVALID(BVALID), .BREADY(BREADY),
    .wrEn(wrEn), .wrIndex(wrIndex), .wrData(wrData), .wrStrb(wrStrb)
  );

  // ----------------------------------------
  // read path
  // ----------------------------------------
  addrFifo #(.FifoDepth(FifoDepth)) u_arFifo (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .inReq(arReq), .inValid(ARVALID), .inReady(ARREADY),
    .outReq(rdReq), .outValid(rdReqValid), .outReady(rdReqReady)
  );

  readEngine #(.MemWords(MemWords)) u_readEngine (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .req(rdReq), .reqValid(rdReqValid), .reqReady(rdReqReady),
    .rBeat(rBeat), .RVALID(RVALID), .RREADY(RREADY),
    .rdEn(rdEn), .rdIndex(rdIndex), .rdData(rdData)
  );

  memArray #(.MemWords(MemWords)) u_mem (
    .ACLK(ACLK),
    .wrEn(wrEn), .wrIndex(wrIndex), .wrData(wrData), .wrStrb(wrStrb),
    .rdEn(rdEn), .rdIndex(rdIndex), .rdData(rdData)
  );

endmodule

// ==== sim/axiMem_props.sv ====
// AXI channel rules on the DUT ports, bound into every axiMemSlave instance
`timescale 1ns/1ns

module axiMemProps import axiMemPkg::*; (
  input logic               ACLK,
  input logic               ARESETn,
  input rBeat_t             rBeat,
  input logic               RVALID,
  input logic               RREADY,
  input logic [IdWidth-1:0] BID,
  input logic               BVALID,
  input logic               BREADY,
  input logic               WREADY
);

  // R beat held under back-pressure
  rHold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    RVALID && !RREADY |=> RVALID && $stable(rBeat))
    else $error("R beat dropped or changed before RREADY");

  bHold: assert property (@(posedge ACLK) disable iff (!ARESETn)
    BVALID && !BREADY |=> BVALID && $stable(BID))
    else $error("B response dropped or changed before BREADY");

  // no new W beat while a response waits
  wBlocked: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(WREADY && BVALID))
    else $error("WREADY high while BVALID is pending");

endmodule

bind axiMemSlave axiMemProps u_props (
  .ACLK(ACLK), .ARESETn(ARESETn),
  .rBeat(rBeat), .RVALID(RVALID), .RREADY(RREADY),
  .BID(BID), .BVALID(BVALID), .BREADY(BREADY),
  .WREADY(WREADY)
);

// ==== sim/tbAxiMem.sv ====
// self-checking testbench, random INCR bursts against a byte-level memory model
// memory is prefilled through AXI first, so every read returns known data
`timescale 1ns/1ns

module tbAxiMem import axiMemPkg::*; ();

  localparam int MemBytes = 1024;
  localparam int MaxWait  = 2000;  // cycles allowed per handshake

  logic               ACLK, ARESETn;
  burstReq_t          awReq, arReq;
  wBeat_t             wBeat;
  rBeat_t             rBeat;
  logic               AWVALID, AWREADY, WVALID, WREADY, BVALID, BREADY;
  logic               ARVALID, ARREADY, RVALID, RREADY;
  logic [IdWidth-1:0] BID;
  logic [1:0]         RRESP;
  logic [7:0]         model [MemBytes];  // byte image of the DUT memory

  axiMemSlave #(.MemBytes(MemBytes), .FifoDepth(4)) u_dut (.*);

  initial begin
    ACLK = 1'b0;
    forever #20 ACLK = ~ACLK;
  end

  // ----------------------------------------
  // checks and model helpers
  // ----------------------------------------
  task automatic expectEqual(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timedOut(input string what);
    $display("no handshake on %s within %0d cycles", what, MaxWait);
    $display("Test failed");
    $fatal(1, "handshake timeout");
  endtask

  // first byte of the word that holds addr, wraps like the memory
  function automatic int byteBase(input logic [31:0] addr);
    return 4 * int'((addr >> 2) % (MemBytes / 4));
  endfunction

  function automatic logic [31:0] modelWord(input logic [31:0] addr);
    int base;
    base = byteBase(addr);
    return {model[base+3], model[base+2], model[base+1], model[base]};
  endfunction

  function automatic logic [31:0] fillWord(input logic [31:0] addr);
    return (addr * 32'h9E3779B1) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  function automatic burstReq_t randReq(input logic [2:0] size);
    burstReq_t req;
    req.id   = 4'($urandom);
    req.len  = 8'($urandom % 16);  // 1 to 16 beats
    req.size = size;
    req.addr = 32'($urandom % MemBytes) & ~((32'd1 << size) - 1);
    return req;
  endfunction

  // ----------------------------------------
  // channel drivers, all enter and leave on a falling edge
  // ----------------------------------------
  task automatic sendAddr(input bit isRead, input burstReq_t req);
    int waitCnt;
    waitCnt = 0;
    if (isRead) begin
      arReq   = req;
      ARVALID = 1'b1;
    end else begin
      awReq   = req;
      AWVALID = 1'b1;
    end
    while (!(isRead ? ARREADY : AWREADY)) begin
      @(negedge ACLK);
      waitCnt++;
      if (waitCnt > MaxWait) timedOut("address channel");
    end
    @(negedge ACLK);
    ARVALID = 1'b0;
    AWVALID = 1'b0;
  endtask

  // mode 0 fill pattern, 1 full strobes, 2 random strobes
  task automatic sendBeats(input burstReq_t req, input int mode);
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    int          waitCnt;
    addr = req.addr;
    for (int beat = 0; beat <= int'(req.len); beat++) begin
      data = (mode == 0) ? fillWord(addr) : $urandom;
      case (req.size)
        3'd0:    strb = 4'b0001 << addr[1:0];  // lane of the byte address
        3'd1:    strb = 4'b0011 << {addr[1], 1'b0};
        default: strb = (mode == 2) ? 4'($urandom) : 4'hF;
      endcase
      for (int lane = 0; lane < 4; lane++) begin
        if (strb[lane]) model[byteBase(addr) + lane] = data[8*lane +: 8];
      end
      wBeat.data = data;
      wBeat.strb = strb;
      wBeat.last = (beat == int'(req.len));
      WVALID     = 1'b1;
      waitCnt    = 0;
      while (!WREADY) begin
        @(negedge ACLK);
        waitCnt++;
        if (waitCnt > MaxWait) timedOut("WREADY");
      end
      @(negedge ACLK);
      addr = addr + (32'd1 << req.size);
    end
    WVALID = 1'b0;
  endtask

  task automatic takeResp(input logic [3:0] id, input bit stall);
    int waitCnt;
    bit done;
    waitCnt = 0;
    done    = 1'b0;
    while (!done) begin
      BREADY = stall ? ($urandom % 3 != 0) : 1'b1;
      if (BVALID && BREADY) begin
        expectEqual("BID", 32'(BID), 32'(id));
        done = 1'b1;
      end
      @(negedge ACLK);  // transfer at the rising edge in between
      waitCnt++;
      if (waitCnt > MaxWait) timedOut("B channel");
    end
    BREADY = 1'b0;
  endtask

  task automatic readBurst(input burstReq_t req, input bit stall);
    logic [31:0] addr;
    int          beat;
    int          waitCnt;
    addr    = req.addr;
    beat    = 0;
    waitCnt = 0;
    while (beat <= int'(req.len)) begin
      RREADY = stall ? ($urandom % 3 != 0) : 1'b1;
      if (RVALID && RREADY) begin
        expectEqual("RDATA", rBeat.data, modelWord(addr));
        expectEqual("RID", 32'(rBeat.id), 32'(req.id));
        expectEqual("RLAST", 32'(rBeat.last), 32'(beat == int'(req.len)));
        expectEqual("RRESP", 32'(RRESP), 32'(0));
        addr    = addr + (32'd1 << req.size);
        beat++;
        waitCnt = 0;
      end
      @(negedge ACLK);
      waitCnt++;
      if (waitCnt > MaxWait) timedOut("R channel");
    end
    RREADY = 1'b0;
  endtask

  task automatic writeBurst(input burstReq_t req, input int mode);
    sendAddr(1'b0, req);
    sendBeats(req, mode);
    takeResp(req.id, 1'b0);
  endtask

  task automatic readBack(input burstReq_t req);
    sendAddr(1'b1, req);
    readBurst(req, 1'b0);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    burstReq_t          req;
    burstReq_t          batch [4];
    logic [IdWidth-1:0] idBase;
    void'($urandom(32'h1337));
    ARESETn = 1'b0;
    awReq   = '0;
    arReq   = '0;
    wBeat   = '0;
    AWVALID = 1'b0;
    WVALID  = 1'b0;
    BREADY  = 1'b0;
    ARVALID = 1'b0;
    RREADY  = 1'b0;
    repeat (16) @(posedge ACLK);
    @(negedge ACLK);
    ARESETn = 1'b1;
    expectEqual("AWREADY", 32'(AWREADY), 32'(0));  // registered, one cycle late
    @(negedge ACLK);
    expectEqual("AWREADY", 32'(AWREADY), 32'(1));
    expectEqual("ARREADY", 32'(ARREADY), 32'(1));
    expectEqual("BVALID", 32'(BVALID), 32'(0));
    expectEqual("RVALID", 32'(RVALID), 32'(0));
    expectEqual("WREADY", 32'(WREADY), 32'(0));

    for (int base = 0; base < MemBytes; base += 64) begin
      req.id   = '0;
      req.addr = 32'(base);
      req.len  = 8'd15;
      req.size = 3'd2;
      writeBurst(req, 0);
    end

    // single beat, full strobes
    req     = randReq(3'd2);
    req.len = '0;
    writeBurst(req, 1);
    readBack(req);

    repeat (40) begin
      req = randReq(3'd2);
      writeBurst(req, 2);
      readBack(req);
    end

    repeat (30) begin
      req = randReq(3'($urandom % 2));  // byte or halfword beats
      writeBurst(req, 2);
      readBack(req);
    end

    // four AW ahead of any W data, stalls on B and R
    repeat (4) begin
      idBase = 4'($urandom);
      for (int i = 0; i < 4; i++) begin
        batch[i]    = randReq(3'd2);
        batch[i].id = idBase + 4'(i);
        sendAddr(1'b0, batch[i]);
      end
      fork
        for (int i = 0; i < 4; i++) sendBeats(batch[i], 2);
        for (int i = 0; i < 4; i++) takeResp(batch[i].id, 1'b1);
      join
      for (int i = 0; i < 4; i++) sendAddr(1'b1, batch[i]);
      for (int i = 0; i < 4; i++) readBurst(batch[i], 1'b1);
    end

    $display("Test passed");
    $finish;
  end

endmodule

// ==== src.f ====
common/axiMemPkg.sv
source/addrFifo.sv
source/memArray.sv
writePath/writeEngine.sv
readPath/readEngine.sv
source/axiMemSlave.sv
sim/axiMem_props.sv
sim/tbAxiMem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbAxiMem
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "RESULT: FAIL"; exit 1; \
	elif grep -q "Test passed" $(LOG); then echo "RESULT: PASS"; \
	else echo "RESULT: no verdict in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
